//--- Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_core_ctrl
FILELIST = core_ctrl.f
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST)
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^All checks passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- common/ctrl_defs.svh
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

`define INST_WIDTH 32
`define REG_ADDR_WIDTH 5

`define PC_SRC_SEL_WIDTH 3
`define IMM_TYPE_WIDTH 2
`define SRC_A_SEL_WIDTH 2
`define SRC_B_SEL_WIDTH 2
`define ALU_OP_WIDTH 4
`define MEM_TYPE_WIDTH 3
`define WB_SRC_SEL_WIDTH 1
`define ECODE_WIDTH 4

// rv32i base opcodes
`define RV32_LOAD 7'b0000011
`define RV32_STORE 7'b0100011
`define RV32_BRANCH 7'b1100011
`define RV32_JAL 7'b1101111
`define RV32_JALR 7'b1100111
`define RV32_MISC_MEM 7'b0001111
`define RV32_OP_IMM 7'b0010011
`define RV32_OP 7'b0110011
`define RV32_AUIPC 7'b0010111
`define RV32_LUI 7'b0110111

`define RV32_FUNCT3_BEQ 3'd0
`define RV32_FUNCT3_BNE 3'd1
`define RV32_FUNCT3_BLT 3'd4
`define RV32_FUNCT3_BGE 3'd5
`define RV32_FUNCT3_BLTU 3'd6
`define RV32_FUNCT3_BGEU 3'd7

`define RV32_FUNCT3_ADD_SUB 3'd0
`define RV32_FUNCT3_SLL 3'd1
`define RV32_FUNCT3_SLT 3'd2
`define RV32_FUNCT3_SLTU 3'd3
`define RV32_FUNCT3_XOR 3'd4
`define RV32_FUNCT3_SRA_SRL 3'd5
`define RV32_FUNCT3_OR 3'd6
`define RV32_FUNCT3_AND 3'd7
`define RV32_FUNCT3_FENCE 3'd0

`define SRC_A_RS1 2'd0
`define SRC_A_PC 2'd1
`define SRC_A_ZERO 2'd2
`define SRC_B_RS2 2'd0
`define SRC_B_IMM 2'd1
`define SRC_B_FOUR 2'd2

`define IMM_I 2'd0
`define IMM_S 2'd1
`define IMM_U 2'd2

`define ALU_OP_ADD 4'd0
`define ALU_OP_SLL 4'd1
`define ALU_OP_XOR 4'd4
`define ALU_OP_OR 4'd6
`define ALU_OP_AND 4'd7
`define ALU_OP_SRL 4'd5
`define ALU_OP_SEQ 4'd8
`define ALU_OP_SNE 4'd9
`define ALU_OP_SUB 4'd10
`define ALU_OP_SRA 4'd11
`define ALU_OP_SLT 4'd12
`define ALU_OP_SGE 4'd13
`define ALU_OP_SLTU 4'd14
`define ALU_OP_SGEU 4'd15

`define PC_PLUS_FOUR 3'd0
`define PC_BRANCH_TARGET 3'd1
`define PC_JAL_TARGET 3'd2
`define PC_JALR_TARGET 3'd3
`define PC_REPLAY 3'd4
`define PC_HANDLER 3'd5

`define WB_SRC_ALU 1'b0
`define WB_SRC_MEM 1'b1

`define ECODE_INST_ADDR_MISALIGNED 4'd0
`define ECODE_ILLEGAL_INST 4'd2
`define ECODE_LOAD_ADDR_MISALIGNED 4'd4
`define ECODE_STORE_ADDR_MISALIGNED 4'd6

`endif

//--- common/ctrl_pkg.sv
`include "ctrl_defs.svh"

package ctrl_pkg;

   typedef struct packed {
      logic [`IMM_TYPE_WIDTH-1:0] imm_type;
      logic [`SRC_A_SEL_WIDTH-1:0] src_a_sel;
      logic [`SRC_B_SEL_WIDTH-1:0] src_b_sel;
      logic [`ALU_OP_WIDTH-1:0] alu_op;
   } dx_ctrl_t;

   typedef struct packed {
      logic en;
      logic wen;
      logic [2:0] size;
      logic [`MEM_TYPE_WIDTH-1:0] mem_type;
   } dmem_req_t;

   typedef struct packed {
      logic stall_if;
      logic kill_if;
      logic stall_dx;
      logic kill_dx;
      logic stall_wb;
      logic kill_wb;
   } stage_ctrl_t;

   typedef struct packed {
      logic wr_reg;
      logic [`REG_ADDR_WIDTH-1:0] reg_to_wr;
      logic [`WB_SRC_SEL_WIDTH-1:0] wb_src_sel;
      logic exception;
      logic [`ECODE_WIDTH-1:0] exception_code;
      logic retire;
   } wb_ctrl_t;

   // decoder flags before the kill gate
   typedef struct packed {
      logic branch_taken;
      logic jal;
      logic jalr;
      logic dmem_en;
      logic dmem_wen;
      logic wr_reg;
      logic uses_rs1;
      logic uses_rs2;
      logic illegal;
      logic [`WB_SRC_SEL_WIDTH-1:0] wb_src_sel;
   } dec_flags_t;

endpackage

//--- common/rv32_pkg.sv
`include "ctrl_defs.svh"

package rv32_pkg;

   typedef struct packed {
      logic [6:0] funct7;
      logic [`REG_ADDR_WIDTH-1:0] rs2;
      logic [`REG_ADDR_WIDTH-1:0] rs1;
      logic [2:0] funct3;
      logic [`REG_ADDR_WIDTH-1:0] rd;
      logic [6:0] opcode;
   } r_type_t;

   typedef struct packed {
      logic [11:0] imm12;
      logic [`REG_ADDR_WIDTH-1:0] rs1;
      logic [2:0] funct3;
      logic [`REG_ADDR_WIDTH-1:0] rd;
      logic [6:0] opcode;
   } i_type_t;

   // same instruction word, two field layouts
   typedef union packed {
      r_type_t r_view;
      i_type_t i_view;
   } rv32_inst_u;

endpackage

//--- core_ctrl.f
+incdir+common
common/rv32_pkg.sv
common/ctrl_pkg.sv
ctrl/inst_decoder.sv
ctrl/hazard_unit.sv
ctrl/pipe_ctrl.sv
ctrl/core_ctrl.sv
verif/clk_gen.sv
verif/tb_core_ctrl.sv

//--- ctrl/core_ctrl.sv
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module core_ctrl
   import rv32_pkg::*;
   import ctrl_pkg::*;
(
   input  logic                          clk,
   input  logic                          reset,
   input  rv32_inst_u                    inst_dx,
   input  logic                          imem_wait,
   input  logic                          imem_badmem,
   input  logic                          dmem_wait,
   input  logic                          dmem_badmem,
   input  logic                          cmp_true,
   output dx_ctrl_t                      dx_ctrl,
   output dmem_req_t                     dmem_req,
   output logic [`PC_SRC_SEL_WIDTH-1:0]  pc_src_sel,
   output logic                          bypass_rs1,
   output logic                          bypass_rs2,
   output stage_ctrl_t                   stage_ctrl,
   output wb_ctrl_t                      wb_ctrl
);

   dec_flags_t dec_flags;
   logic load_use;
   logic wr_reg_wb;
   logic [`REG_ADDR_WIDTH-1:0] reg_to_wr_wb;
   logic load_in_wb;

   inst_decoder u_decoder (
      .inst_dx   (inst_dx),
      .cmp_true  (cmp_true),
      .dx_ctrl   (dx_ctrl),
      .dec_flags (dec_flags)
   );

   pipe_ctrl u_pipe_ctrl (
      .clk          (clk),
      .reset        (reset),
      .dec_flags    (dec_flags),
      .inst_dx      (inst_dx),
      .imem_wait    (imem_wait),
      .imem_badmem  (imem_badmem),
      .dmem_wait    (dmem_wait),
      .dmem_badmem  (dmem_badmem),
      .load_use     (load_use),
      .dmem_req     (dmem_req),
      .pc_src_sel   (pc_src_sel),
      .stage_ctrl   (stage_ctrl),
      .wb_ctrl      (wb_ctrl),
      .wr_reg_wb    (wr_reg_wb),
      .reg_to_wr_wb (reg_to_wr_wb),
      .load_in_wb   (load_in_wb)
   );

   hazard_unit u_hazard (
      .rs1          (inst_dx.r_view.rs1),
      .rs2          (inst_dx.r_view.rs2),
      .uses_rs1     (dec_flags.uses_rs1),
      .uses_rs2     (dec_flags.uses_rs2),
      .wr_reg_wb    (wr_reg_wb),
      .reg_to_wr_wb (reg_to_wr_wb),
      .load_in_wb   (load_in_wb),
      .bypass_rs1   (bypass_rs1),
      .bypass_rs2   (bypass_rs2),
      .load_use     (load_use)
   );

endmodule

//--- ctrl/hazard_unit.sv
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module hazard_unit (
   input  logic [`REG_ADDR_WIDTH-1:0] rs1,
   input  logic [`REG_ADDR_WIDTH-1:0] rs2,
   input  logic                       uses_rs1,
   input  logic                       uses_rs2,
   input  logic                       wr_reg_wb,
   input  logic [`REG_ADDR_WIDTH-1:0] reg_to_wr_wb,
   input  logic                       load_in_wb,
   output logic                       bypass_rs1,
   output logic                       bypass_rs2,
   output logic                       load_use
);

   logic raw_rs1;
   logic raw_rs2;

   // x0 never carries a dependency
   assign raw_rs1 = wr_reg_wb && uses_rs1 && (rs1 == reg_to_wr_wb) && (rs1 != '0);
   assign raw_rs2 = wr_reg_wb && uses_rs2 && (rs2 == reg_to_wr_wb) && (rs2 != '0);

   assign bypass_rs1 = raw_rs1 && !load_in_wb;
   assign bypass_rs2 = raw_rs2 && !load_in_wb;
   assign load_use = load_in_wb && (raw_rs1 || raw_rs2);  // load data not ready yet

   always_comb begin
      assert (!(load_use && (bypass_rs1 || bypass_rs2)));
   end

endmodule

//--- ctrl/inst_decoder.sv
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module inst_decoder
   import rv32_pkg::*;
   import ctrl_pkg::*;
(
   input  rv32_inst_u inst_dx,
   input  logic       cmp_true,
   output dx_ctrl_t   dx_ctrl,
   output dec_flags_t dec_flags
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic [`ALU_OP_WIDTH-1:0] alu_op_arith;
   logic known_op;

   assign opcode = inst_dx.r_view.opcode;
   assign funct3 = inst_dx.r_view.funct3;
   assign funct7 = inst_dx.r_view.funct7;

   assign known_op = opcode inside {`RV32_LOAD, `RV32_STORE, `RV32_BRANCH, `RV32_JAL,
                                    `RV32_JALR, `RV32_MISC_MEM, `RV32_OP_IMM, `RV32_OP,
                                    `RV32_AUIPC, `RV32_LUI};

   always_comb begin
      case (funct3)
         `RV32_FUNCT3_ADD_SUB: alu_op_arith = (opcode == `RV32_OP && funct7[5]) ?
                                              `ALU_OP_SUB : `ALU_OP_ADD;
         `RV32_FUNCT3_SLL:     alu_op_arith = `ALU_OP_SLL;
         `RV32_FUNCT3_SLT:     alu_op_arith = `ALU_OP_SLT;
         `RV32_FUNCT3_SLTU:    alu_op_arith = `ALU_OP_SLTU;
         `RV32_FUNCT3_XOR:     alu_op_arith = `ALU_OP_XOR;
         `RV32_FUNCT3_SRA_SRL: alu_op_arith = funct7[5] ? `ALU_OP_SRA : `ALU_OP_SRL;
         `RV32_FUNCT3_OR:      alu_op_arith = `ALU_OP_OR;
         default:              alu_op_arith = `ALU_OP_AND;
      endcase
   end

   always_comb begin
      dx_ctrl.imm_type = `IMM_I;
      dx_ctrl.src_a_sel = `SRC_A_RS1;
      dx_ctrl.src_b_sel = `SRC_B_IMM;
      dx_ctrl.alu_op = `ALU_OP_ADD;
      dec_flags = '0;
      dec_flags.uses_rs1 = 1'b1;
      dec_flags.wb_src_sel = `WB_SRC_ALU;
      case (opcode)
         `RV32_LOAD: begin
            dec_flags.dmem_en = 1'b1;
            dec_flags.wr_reg = 1'b1;
            dec_flags.wb_src_sel = `WB_SRC_MEM;
         end
         `RV32_STORE: begin
            dx_ctrl.imm_type = `IMM_S;
            dec_flags.uses_rs2 = 1'b1;
            dec_flags.dmem_en = 1'b1;
            dec_flags.dmem_wen = 1'b1;
         end
         `RV32_BRANCH: begin
            dx_ctrl.src_b_sel = `SRC_B_RS2;
            dec_flags.uses_rs2 = 1'b1;
            dec_flags.branch_taken = cmp_true;
            case (funct3)
               `RV32_FUNCT3_BEQ:  dx_ctrl.alu_op = `ALU_OP_SEQ;
               `RV32_FUNCT3_BNE:  dx_ctrl.alu_op = `ALU_OP_SNE;
               `RV32_FUNCT3_BLT:  dx_ctrl.alu_op = `ALU_OP_SLT;
               `RV32_FUNCT3_BGE:  dx_ctrl.alu_op = `ALU_OP_SGE;
               `RV32_FUNCT3_BLTU: dx_ctrl.alu_op = `ALU_OP_SLTU;
               `RV32_FUNCT3_BGEU: dx_ctrl.alu_op = `ALU_OP_SGEU;
               default:           dec_flags.illegal = 1'b1;
            endcase
         end
         `RV32_JAL, `RV32_JALR: begin
            // link value is pc + 4
            dx_ctrl.src_a_sel = `SRC_A_PC;
            dx_ctrl.src_b_sel = `SRC_B_FOUR;
            dec_flags.wr_reg = 1'b1;
            dec_flags.jal = (opcode == `RV32_JAL);
            dec_flags.jalr = (opcode == `RV32_JALR);
            dec_flags.uses_rs1 = (opcode == `RV32_JALR);
            dec_flags.illegal = (opcode == `RV32_JALR) && (inst_dx.i_view.funct3 != 3'd0);
         end
         `RV32_MISC_MEM: begin
            // plain fence only, treated as a no-op
            dec_flags.illegal = (funct3 != `RV32_FUNCT3_FENCE) ||
                                (inst_dx.i_view.imm12[11:8] != 4'd0) ||
                                (inst_dx.i_view.rs1 != '0) || (inst_dx.i_view.rd != '0);
         end
         `RV32_OP_IMM: begin
            dx_ctrl.alu_op = alu_op_arith;
            dec_flags.wr_reg = 1'b1;
         end
         `RV32_OP: begin
            dx_ctrl.src_b_sel = `SRC_B_RS2;
            dx_ctrl.alu_op = alu_op_arith;
            dec_flags.uses_rs2 = 1'b1;
            dec_flags.wr_reg = 1'b1;
         end
         `RV32_AUIPC, `RV32_LUI: begin
            dx_ctrl.imm_type = `IMM_U;
            dx_ctrl.src_a_sel = (opcode == `RV32_LUI) ? `SRC_A_ZERO : `SRC_A_PC;
            dec_flags.uses_rs1 = 1'b0;
            dec_flags.wr_reg = 1'b1;
         end
         default: dec_flags.illegal = 1'b1;
      endcase
      // an unknown opcode must never reach the register file
      assert (known_op || !(dec_flags.illegal && dec_flags.wr_reg));
   end

endmodule

//--- ctrl/pipe_ctrl.sv
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module pipe_ctrl
   import rv32_pkg::*;
   import ctrl_pkg::*;
(
   input  logic                          clk,
   input  logic                          reset,
   input  dec_flags_t                    dec_flags,
   input  rv32_inst_u                    inst_dx,
   input  logic                          imem_wait,
   input  logic                          imem_badmem,
   input  logic                          dmem_wait,
   input  logic                          dmem_badmem,
   input  logic                          load_use,
   output dmem_req_t                     dmem_req,
   output logic [`PC_SRC_SEL_WIDTH-1:0]  pc_src_sel,
   output stage_ctrl_t                   stage_ctrl,
   output wb_ctrl_t                      wb_ctrl,
   output logic                          wr_reg_wb,
   output logic [`REG_ADDR_WIDTH-1:0]    reg_to_wr_wb,
   output logic                          load_in_wb
);

   logic replay_if, ex_if, stall_if, kill_if;
   logic had_ex_dx, prev_killed_dx, ex_dx, stall_dx, kill_dx, killed_dx;
   logic branch_taken, jal, jalr, redirect;
   logic [`ECODE_WIDTH-1:0] ex_code_dx;
   logic prev_killed_wb, had_ex_wb, wr_reg_unkilled_wb, store_in_wb, dmem_en_wb;
   logic [`WB_SRC_SEL_WIDTH-1:0] wb_src_sel_wb;
   logic [`ECODE_WIDTH-1:0] prev_ex_code_wb;
   logic dmem_error, ex_wb, stall_wb, kill_wb;

   // IF stage
   assign ex_if = imem_badmem && !imem_wait && !redirect && !replay_if;
   assign stall_if = stall_dx || (imem_wait && !redirect && !ex_wb);
   assign kill_if = stall_if || ex_if || ex_dx || ex_wb || redirect || replay_if;

   // DX stage, no stall while an exception is pending
   assign ex_dx = had_ex_dx || dec_flags.illegal;
   assign stall_dx = stall_wb || (load_use && !(ex_dx || ex_wb));
   assign kill_dx = stall_dx || ex_dx || ex_wb;
   assign killed_dx = prev_killed_dx || kill_dx;
   assign ex_code_dx = (!had_ex_dx && dec_flags.illegal) ? `ECODE_ILLEGAL_INST :
                                                           `ECODE_INST_ADDR_MISALIGNED;

   assign branch_taken = dec_flags.branch_taken && !kill_dx;
   assign jal = dec_flags.jal && !kill_dx;
   assign jalr = dec_flags.jalr && !kill_dx;
   assign redirect = branch_taken || jal || jalr;

   assign dmem_req.en = dec_flags.dmem_en && !kill_dx;
   assign dmem_req.wen = dec_flags.dmem_wen && !kill_dx;
   assign dmem_req.size = {1'b0, inst_dx.r_view.funct3[1:0]};
   assign dmem_req.mem_type = inst_dx.r_view.funct3;

   always_comb begin
      if (ex_wb)
         pc_src_sel = `PC_HANDLER;
      else if (replay_if || (stall_if && !imem_wait))
         pc_src_sel = `PC_REPLAY;
      else if (branch_taken)
         pc_src_sel = `PC_BRANCH_TARGET;
      else if (jal)
         pc_src_sel = `PC_JAL_TARGET;
      else if (jalr)
         pc_src_sel = `PC_JALR_TARGET;
      else
         pc_src_sel = `PC_PLUS_FOUR;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         replay_if <= 1'b1;
         had_ex_dx <= 1'b0;
         prev_killed_dx <= 1'b0;
         prev_killed_wb <= 1'b1;  // wb starts empty
         had_ex_wb <= 1'b0;
         wr_reg_unkilled_wb <= 1'b0;
         store_in_wb <= 1'b0;
         dmem_en_wb <= 1'b0;
      end else begin
         replay_if <= redirect && imem_wait;  // target fetch was lost
         if (!stall_dx) begin
            had_ex_dx <= ex_if;
            prev_killed_dx <= kill_if;
         end
         if (!stall_wb) begin
            prev_killed_wb <= killed_dx;
            had_ex_wb <= ex_dx;
            wr_reg_unkilled_wb <= dec_flags.wr_reg && !kill_dx;
            store_in_wb <= dmem_req.wen;
            dmem_en_wb <= dmem_req.en;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!stall_wb) begin
         wb_src_sel_wb <= dec_flags.wb_src_sel;
         prev_ex_code_wb <= ex_code_dx;
         reg_to_wr_wb <= inst_dx.r_view.rd;
      end
   end

   // WB stage
   assign dmem_error = dmem_badmem && dmem_en_wb;
   assign ex_wb = had_ex_wb || dmem_error;
   assign stall_wb = dmem_wait && dmem_en_wb && !ex_wb;
   assign kill_wb = stall_wb || ex_wb;
   assign wr_reg_wb = wr_reg_unkilled_wb && !kill_wb;
   assign load_in_wb = dmem_en_wb && !store_in_wb;

   assign wb_ctrl.wr_reg = wr_reg_wb;
   assign wb_ctrl.reg_to_wr = reg_to_wr_wb;
   assign wb_ctrl.wb_src_sel = wb_src_sel_wb;
   assign wb_ctrl.exception = ex_wb;
   assign wb_ctrl.retire = !(prev_killed_wb || kill_wb);
   // earlier causes win over a memory error
   assign wb_ctrl.exception_code = had_ex_wb ? prev_ex_code_wb :
                                   wr_reg_unkilled_wb ? `ECODE_LOAD_ADDR_MISALIGNED :
                                                        `ECODE_STORE_ADDR_MISALIGNED;

   assign stage_ctrl.stall_if = stall_if;
   assign stage_ctrl.kill_if = kill_if;
   assign stage_ctrl.stall_dx = stall_dx;
   assign stage_ctrl.kill_dx = kill_dx;
   assign stage_ctrl.stall_wb = stall_wb;
   assign stage_ctrl.kill_wb = kill_wb;

   a_no_retire_on_exception: assert property (
      @(posedge clk) disable iff (reset) wb_ctrl.exception |-> !wb_ctrl.retire);

endmodule

//--- verif/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;  // 4 ns period
   end

   initial begin
      reset = 1'b1;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

//--- verif/tb_core_ctrl.sv
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module tb_core_ctrl
   import rv32_pkg::*;
   import ctrl_pkg::*;
;

   localparam logic [31:0] NOP = 32'h0000_0013;  // addi x0, x0, 0
   localparam int CYCLE_LIMIT = 4 + 40 + 18 + 10 + 8 + 4 + 16 + 50;

   typedef struct packed {
      dx_ctrl_t ctrl;
      dmem_req_t req;
      logic illegal;
      logic [`ECODE_WIDTH-1:0] ecode;
   } expect_t;

   logic clk, reset;
   rv32_inst_u inst_dx;
   logic imem_wait, imem_badmem, dmem_wait, dmem_badmem, cmp_true;
   dx_ctrl_t dx_ctrl;
   dmem_req_t dmem_req;
   logic [`PC_SRC_SEL_WIDTH-1:0] pc_src_sel;
   logic bypass_rs1, bypass_rs2;
   stage_ctrl_t stage_ctrl;
   wb_ctrl_t wb_ctrl;

   int checks = 0;
   int errors = 0;
   int test_checks, test_errors;
   int cycle_count = 0;

   clk_gen u_clk_gen (.clk(clk), .reset(reset));

   core_ctrl u_dut (
      .clk(clk), .reset(reset), .inst_dx(inst_dx), .imem_wait(imem_wait),
      .imem_badmem(imem_badmem), .dmem_wait(dmem_wait), .dmem_badmem(dmem_badmem),
      .cmp_true(cmp_true), .dx_ctrl(dx_ctrl), .dmem_req(dmem_req), .pc_src_sel(pc_src_sel),
      .bypass_rs1(bypass_rs1), .bypass_rs2(bypass_rs2), .stage_ctrl(stage_ctrl),
      .wb_ctrl(wb_ctrl)
   );

   function automatic logic [3:0] arith_op(input logic [2:0] f3, input logic is_op,
                                           input logic f7b5);
      case (f3)
         3'd0: return (is_op && f7b5) ? `ALU_OP_SUB : `ALU_OP_ADD;
         3'd1: return `ALU_OP_SLL;
         3'd2: return `ALU_OP_SLT;
         3'd3: return `ALU_OP_SLTU;
         3'd4: return `ALU_OP_XOR;
         3'd5: return f7b5 ? `ALU_OP_SRA : `ALU_OP_SRL;
         3'd6: return `ALU_OP_OR;
         default: return `ALU_OP_AND;
      endcase
   endfunction

   function automatic expect_t ref_decode(input logic [31:0] w);
      expect_t e;
      logic [2:0] f3;
      f3 = w[14:12];
      e = '0;
      e.ctrl.imm_type = `IMM_I;
      e.ctrl.src_a_sel = `SRC_A_RS1;
      e.ctrl.src_b_sel = `SRC_B_IMM;
      e.ctrl.alu_op = `ALU_OP_ADD;
      e.req.en = (w[6:0] == `RV32_LOAD) || (w[6:0] == `RV32_STORE);
      e.req.wen = (w[6:0] == `RV32_STORE);
      e.req.mem_type = f3;
      case (f3)
         3'd0, 3'd4: e.req.size = 3'd0;  // byte
         3'd1, 3'd5: e.req.size = 3'd1;  // halfword
         3'd2, 3'd6: e.req.size = 3'd2;  // word
         default: e.req.size = 3'd3;
      endcase
      case (w[6:0])
         `RV32_LOAD: ;
         `RV32_STORE: e.ctrl.imm_type = `IMM_S;
         `RV32_BRANCH: begin
            e.ctrl.src_b_sel = `SRC_B_RS2;
            case (f3)
               3'd0: e.ctrl.alu_op = `ALU_OP_SEQ;
               3'd1: e.ctrl.alu_op = `ALU_OP_SNE;
               3'd4: e.ctrl.alu_op = `ALU_OP_SLT;
               3'd5: e.ctrl.alu_op = `ALU_OP_SGE;
               3'd6: e.ctrl.alu_op = `ALU_OP_SLTU;
               3'd7: e.ctrl.alu_op = `ALU_OP_SGEU;
               default: e.illegal = 1'b1;
            endcase
         end
         `RV32_JAL, `RV32_JALR: begin
            e.ctrl.src_a_sel = `SRC_A_PC;
            e.ctrl.src_b_sel = `SRC_B_FOUR;
            e.illegal = (w[6:0] == `RV32_JALR) && (f3 != 3'd0);
         end
         `RV32_MISC_MEM:
            e.illegal = (f3 != 3'd0) || (w[31:28] != 4'd0) || (w[19:15] != 5'd0) ||
                        (w[11:7] != 5'd0);
         `RV32_OP_IMM: e.ctrl.alu_op = arith_op(f3, 1'b0, w[30]);
         `RV32_OP: begin
            e.ctrl.src_b_sel = `SRC_B_RS2;
            e.ctrl.alu_op = arith_op(f3, 1'b1, w[30]);
         end
         `RV32_LUI: begin
            e.ctrl.imm_type = `IMM_U;
            e.ctrl.src_a_sel = `SRC_A_ZERO;
         end
         `RV32_AUIPC: begin
            e.ctrl.imm_type = `IMM_U;
            e.ctrl.src_a_sel = `SRC_A_PC;
         end
         default: e.illegal = 1'b1;
      endcase
      e.ecode = e.illegal ? `ECODE_ILLEGAL_INST : `ECODE_INST_ADDR_MISALIGNED;
      return e;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED time %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic drive_cycle(input logic [31:0] w, input logic cmp, input logic dwait,
                              input logic dbad);
      @(posedge clk);
      inst_dx <= w;
      cmp_true <= cmp;
      dmem_wait <= dwait;
      dmem_badmem <= dbad;
      @(negedge clk);
   endtask

   task automatic begin_test();
      test_checks = checks;
      test_errors = errors;
   endtask

   task automatic end_test(input string name);
      $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
               errors - test_errors);
   endtask

   // decoder outputs against the reference, sampled before the next drive
   always @(posedge clk) begin
      expect_t exp_ctrl;
      if (!reset) begin
         exp_ctrl = ref_decode(inst_dx);
         check_value("dx_ctrl", dx_ctrl, exp_ctrl.ctrl);
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Checks failed");
         $finish;
      end
   end

   initial begin
      logic [31:0] w;
      logic [6:0] op;
      logic [4:0] r, other;
      expect_t exp_dec;
      int n, stalled;
      logic [6:0] rand_ops [6];
      logic [6:0] bad_ops [3];
      rand_ops = '{`RV32_OP, `RV32_OP_IMM, `RV32_LUI, `RV32_AUIPC, `RV32_LOAD, `RV32_STORE};
      bad_ops = '{7'b0000000, 7'b1111111, 7'b1011011};
      void'($urandom(32'haff46f25));
      inst_dx = NOP;
      imem_wait = 1'b0;
      imem_badmem = 1'b0;
      dmem_wait = 1'b0;
      dmem_badmem = 1'b0;
      cmp_true = 1'b0;
      do @(negedge clk); while (reset);

      begin_test();
      for (int i = 0; i < 40; i++) begin
         op = rand_ops[$urandom % 6];
         w = {$urandom} & 32'hffff_f07f;  // rd = x0 keeps hazards out
         w[6:0] = op;
         drive_cycle(w, 1'b0, 1'b0, 1'b0);
         exp_dec = ref_decode(w);
         check_value("dmem_req", dmem_req, exp_dec.req);
      end
      end_test("random decode");

      begin_test();
      for (int i = 0; i < 6; i++) begin
         w = $urandom;
         if (i < 3)
            w[6:0] = bad_ops[i];
         else begin
            w[6:0] = `RV32_JALR;
            w[14:12] = 3'd1 + 3'($urandom % 7);
         end
         exp_dec = ref_decode(w);
         drive_cycle(w, 1'b0, 1'b0, 1'b0);
         check_value("illegal flag", u_dut.u_decoder.dec_flags.illegal, exp_dec.illegal);
         drive_cycle(NOP, 1'b0, 1'b0, 1'b0);
         check_value("wb_ctrl.exception", wb_ctrl.exception, 1);
         check_value("wb_ctrl.exception_code", wb_ctrl.exception_code, exp_dec.ecode);
         check_value("wb_ctrl.retire", wb_ctrl.retire, 0);
         check_value("pc_src_sel", pc_src_sel, `PC_HANDLER);
         drive_cycle(NOP, 1'b0, 1'b0, 1'b0);
      end
      end_test("illegal instructions");

      begin_test();
      for (int k = 0; k < 5; k++) begin
         r = (k == 4) ? 5'd0 : 5'd1 + 5'($urandom % 31);
         other = (k == 4) ? 5'd0 : 5'((r % 31) + 1);
         drive_cycle({12'h05a, 5'd0, 3'd0, r, `RV32_OP_IMM}, 1'b0, 1'b0, 1'b0);
         if (k[0])
            w = {7'd0, r, other, 3'd0, 5'd0, `RV32_OP};
         else
            w = {7'd0, other, r, 3'd0, 5'd0, `RV32_OP};
         drive_cycle(w, 1'b0, 1'b0, 1'b0);
         check_value("bypass_rs1", bypass_rs1, (r != 0) && !k[0]);
         check_value("bypass_rs2", bypass_rs2, (r != 0) && k[0]);
         check_value("stage_ctrl.stall_dx", stage_ctrl.stall_dx, 0);
         check_value("wb_ctrl.reg_to_wr", wb_ctrl.reg_to_wr, r);
         check_value("wb_ctrl.wb_src_sel", wb_ctrl.wb_src_sel, `WB_SRC_ALU);
      end
      end_test("bypass");

      begin_test();
      for (int k = 0; k < 2; k++) begin
         r = 5'd1 + 5'($urandom % 31);
         drive_cycle({12'h010, 5'd0, 3'd2, r, `RV32_LOAD}, 1'b0, 1'b0, 1'b0);
         w = {7'd0, 5'd0, r, 3'd0, 5'd0, `RV32_OP};
         drive_cycle(w, 1'b0, 1'b0, 1'b0);
         check_value("stage_ctrl.stall_dx", stage_ctrl.stall_dx, 1);
         check_value("stage_ctrl.kill_dx", stage_ctrl.kill_dx, 1);
         check_value("bypass_rs1", bypass_rs1, 0);
         check_value("wb_ctrl.retire", wb_ctrl.retire, 1);
         check_value("wb_ctrl.wr_reg", wb_ctrl.wr_reg, 1);
         check_value("wb_ctrl.reg_to_wr", wb_ctrl.reg_to_wr, r);
         check_value("wb_ctrl.wb_src_sel", wb_ctrl.wb_src_sel, `WB_SRC_MEM);
         drive_cycle(w, 1'b0, 1'b0, 1'b0);  // held by the stall
         check_value("stage_ctrl.stall_dx", stage_ctrl.stall_dx, 0);
         check_value("bypass_rs1", bypass_rs1, 0);
         drive_cycle(NOP, 1'b0, 1'b0, 1'b0);
      end
      end_test("load use");

      begin_test();
      drive_cycle({7'd0, 5'd0, 5'd0, 3'd0, 5'd0, `RV32_BRANCH}, 1'b1, 1'b0, 1'b0);
      check_value("pc_src_sel", pc_src_sel, `PC_BRANCH_TARGET);
      check_value("stage_ctrl.kill_if", stage_ctrl.kill_if, 1);
      drive_cycle(NOP, 1'b0, 1'b0, 1'b0);
      drive_cycle({20'h00100, 5'd0, `RV32_JAL}, 1'b0, 1'b0, 1'b0);
      check_value("pc_src_sel", pc_src_sel, `PC_JAL_TARGET);
      check_value("stage_ctrl.kill_if", stage_ctrl.kill_if, 1);
      drive_cycle(NOP, 1'b0, 1'b0, 1'b0);
      end_test("redirect");

      begin_test();
      n = 1 + $urandom % 8;
      stalled = 0;
      drive_cycle({12'h020, 5'd0, 3'd2, 5'd0, `RV32_LOAD}, 1'b0, 1'b0, 1'b0);
      for (int i = 0; i < n; i++) begin
         drive_cycle(NOP, 1'b0, 1'b1, 1'b0);
         if (stage_ctrl.stall_wb && stage_ctrl.stall_dx && stage_ctrl.stall_if)
            stalled++;
      end
      drive_cycle(NOP, 1'b0, 1'b0, 1'b0);
      check_value("stage_ctrl.stall_wb", stage_ctrl.stall_wb, 0);
      check_value("wb_ctrl.retire", wb_ctrl.retire, 1);
      check_value("stalled cycles", stalled, n);
      drive_cycle({12'h021, 5'd0, 3'd2, 5'd0, `RV32_LOAD}, 1'b0, 1'b0, 1'b0);
      drive_cycle(NOP, 1'b0, 1'b0, 1'b1);
      check_value("wb_ctrl.exception", wb_ctrl.exception, 1);
      check_value("wb_ctrl.exception_code", wb_ctrl.exception_code,
                  `ECODE_LOAD_ADDR_MISALIGNED);
      check_value("stage_ctrl.kill_wb", stage_ctrl.kill_wb, 1);
      check_value("pc_src_sel", pc_src_sel, `PC_HANDLER);
      drive_cycle(NOP, 1'b0, 1'b0, 1'b0);
      drive_cycle({7'd0, 5'd0, 5'd0, 3'd2, 5'd3, `RV32_STORE}, 1'b0, 1'b0, 1'b0);
      drive_cycle(NOP, 1'b0, 1'b0, 1'b1);
      check_value("wb_ctrl.exception", wb_ctrl.exception, 1);
      check_value("wb_ctrl.exception_code", wb_ctrl.exception_code,
                  `ECODE_STORE_ADDR_MISALIGNED);
      drive_cycle(NOP, 1'b0, 1'b0, 1'b0);
      end_test("dmem wait and errors");

      $display("total: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule
